/* common/fme_fetch_settings.svh */
// Global settings for the FME reference fetch unit
//   motion-vector width and search range offsets
//   pixel depth, cache word and output row sizes
//   search-window coordinate widths

`ifndef FME_FETCH_SETTINGS_SVH
`define FME_FETCH_SETTINGS_SVH

// integer motion vector, signed
`define FME_MV_W        6

// search window offsets, center of window to its top left corner
`define FME_SR_HOR      32
`define FME_SR_VER      16

// pixel and word geometry
`define FME_PEL_W       8
`define FME_CACHE_PELS  16   // pixels per aligned cache word
`define FME_ROW_PELS    14   // 8 block pixels + 6 interpolation margin

// signed search-window coordinates
`define FME_SWX_W       8
`define FME_SWY_W       7

`endif

/* common/fme_fetch_pkg.sv */
// Shared types of the FME reference fetch unit
//   partition and sub-partition encodings
//   pixel, cache word and output row types
//   block shape record used by the sequencer

`include "fme_fetch_settings.svh"

package fme_fetch_pkg;

  // macroblock partition
  typedef enum logic [1:0] {
    P_16X16 = 2'd0,
    P_16X8  = 2'd1,
    P_8X16  = 2'd2,
    P_8X8   = 2'd3
  } mb_type_e;

  // 8x8 sub-partition, codes 2 and 3 behave like SUB_8X8
  typedef enum logic [1:0] {
    SUB_8X8 = 2'd0,
    SUB_8X4 = 2'd1
  } sub_type_e;

  typedef logic [`FME_PEL_W-1:0] pel_t;

  // pixel i sits at bits i*FME_PEL_W and up
  typedef logic [`FME_CACHE_PELS*`FME_PEL_W-1:0] cache_word_t;
  typedef logic [`FME_ROW_PELS*`FME_PEL_W-1:0]   fifo_row_t;

  // limits of the three fetch counters, all inclusive
  typedef struct packed {
    logic [4:0] last_row;   // 21, 13 or 9
    logic [1:0] last_part;
    logic [1:0] last_sub;
  } shape_t;

endpackage

/* common/fetch_pos_if.sv */
// Block position and row-step events
//   sequencer side: busy flag and the partition, sub-block and row counters
//   address side: read issue and end-of-row strobes

`timescale 1ns/1ns

interface fetch_pos_if;

  logic       busy;       // macroblock in progress
  logic [1:0] part_cnt;
  logic [1:0] sub_cnt;
  logic [4:0] row_cnt;

  logic       rd_step;    // a cache read goes out this cycle
  logic       row_done;   // this read completes the row

  modport seq (
    output busy,
    output part_cnt,
    output sub_cnt,
    output row_cnt,
    input  rd_step,
    input  row_done
  );

  modport addr (
    input  busy,
    input  part_cnt,
    input  sub_cnt,
    input  row_cnt,
    output rd_step,
    output row_done
  );

endinterface

/* fme_fetch/block_sequencer.sv */
// Block sequencer
//   partition and sub-type latch, shape decode
//   idle / fetch FSM
//   row, sub-block and partition counters
//   motion-vector table address

`timescale 1ns/1ns

module block_sequencer (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     start_wr_i,
  input  fme_fetch_pkg::mb_type_e  mb_type_i,
  input  fme_fetch_pkg::sub_type_e sub_mb_type_i,
  output logic [3:0]               mv0_addr_o,
  output logic [1:0]               part_o,
  output logic                     rddone_o,
  fetch_pos_if.seq                 pos
);

  typedef enum logic {
    S_IDLE  = 1'b0,
    S_FETCH = 1'b1
  } state_e;

  state_e                   state_q;
  fme_fetch_pkg::mb_type_e  mb_type_q;
  fme_fetch_pkg::sub_type_e sub_type_q;
  fme_fetch_pkg::shape_t    shape;

  logic [4:0] row_q;
  logic [1:0] sub_q;
  logic [1:0] part_q;

  logic row_step;
  logic end_blk;
  logic end_part;
  logic end_mb;

  // ************************************************************************
  // shape decode
  // ************************************************************************
  always_comb begin
    case (mb_type_q)
      fme_fetch_pkg::P_16X16,
      fme_fetch_pkg::P_8X16: shape = '{last_row: 5'd21, last_part: 2'd1, last_sub: 2'd0};
      fme_fetch_pkg::P_16X8: shape = '{last_row: 5'd13, last_part: 2'd3, last_sub: 2'd0};
      default: begin
        if (sub_type_q == fme_fetch_pkg::SUB_8X4) begin
          shape = '{last_row: 5'd9, last_part: 2'd3, last_sub: 2'd1};
        end else begin
          shape = '{last_row: 5'd13, last_part: 2'd3, last_sub: 2'd0};
        end
      end
    endcase
  end

  assign row_step = pos.rd_step & pos.row_done;
  assign end_blk  = row_step & (row_q == shape.last_row);
  assign end_part = end_blk & (sub_q == shape.last_sub);
  assign end_mb   = end_part & (part_q == shape.last_part);

  // ************************************************************************
  // FSM
  // ************************************************************************
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= S_IDLE;
      mb_type_q  <= fme_fetch_pkg::P_16X16;
      sub_type_q <= fme_fetch_pkg::SUB_8X8;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (start_wr_i) begin
            state_q    <= S_FETCH;
            mb_type_q  <= mb_type_i;   // held for the whole macroblock
            sub_type_q <= sub_mb_type_i;
          end
        end
        default: begin
          if (end_mb) state_q <= S_IDLE;
        end
      endcase
    end
  end

  // counters wrap to zero at the end of a macroblock
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      row_q  <= '0;
      sub_q  <= '0;
      part_q <= '0;
    end else if (row_step) begin
      row_q <= end_blk ? 5'd0 : row_q + 5'd1;
      if (end_part) sub_q <= 2'd0;
      else if (end_blk) sub_q <= sub_q + 2'd1;
      if (end_mb) part_q <= 2'd0;
      else if (end_part) part_q <= part_q + 2'd1;
    end
  end

  // vector table, 4 entries per 8x8 quadrant, 2 per 8x4 half
  always_comb begin
    case (mb_type_q)
      fme_fetch_pkg::P_16X16: mv0_addr_o = 4'd0;
      fme_fetch_pkg::P_16X8:  mv0_addr_o = {part_q[1], 3'b000};
      fme_fetch_pkg::P_8X16:  mv0_addr_o = {part_q, 2'b00};
      default: begin
        if (sub_type_q == fme_fetch_pkg::SUB_8X4) mv0_addr_o = {part_q, sub_q[0], 1'b0};
        else mv0_addr_o = {part_q, 2'b00};
      end
    endcase
  end

  assign pos.busy     = (state_q == S_FETCH);
  assign pos.part_cnt = part_q;
  assign pos.sub_cnt  = sub_q;
  assign pos.row_cnt  = row_q;

  assign part_o   = part_q;
  assign rddone_o = end_mb;   // last read of the macroblock

endmodule

/* fme_fetch/pel_address.sv */
// Search-window pixel address
//   cache read gating by the FIFO handshake
//   block origin + vector + search offset + row / column
//   column counter and end-of-row detection

`timescale 1ns/1ns
`include "fme_fetch_settings.svh"

module pel_address (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         full_i,
  input  logic                         ft_go_ahead_i,
  input  logic signed [`FME_MV_W-1:0]  mv_x_i,
  input  logic signed [`FME_MV_W-1:0]  mv_y_i,
  fetch_pos_if.addr                    pos,
  output logic                         rden_o,
  output logic signed [`FME_SWX_W-1:0] pel_x_o,
  output logic signed [`FME_SWY_W-1:0] pel_y_o,
  output logic [3:0]                   phase_o,
  output logic [3:0]                   col_o
);

  localparam int MARGIN_L = 3;   // left half of the 6-pixel filter margin

  localparam logic [`FME_SWX_W-1:0] X_OFS = `FME_SWX_W'(`FME_SR_HOR - MARGIN_L);
  localparam logic [`FME_SWY_W-1:0] Y_OFS = `FME_SWY_W'(`FME_SR_VER);

  logic [`FME_SWX_W-1:0] org_x;
  logic [`FME_SWY_W-1:0] org_y;
  logic [`FME_SWX_W-1:0] mv_x_ext;
  logic [`FME_SWY_W-1:0] mv_y_ext;
  logic [`FME_SWX_W-1:0] pel_x;
  logic [`FME_SWY_W-1:0] pel_y;

  logic [3:0] col_q;
  logic [4:0] span;    // pixels delivered by this read
  logic [4:0] reach;   // column after this read
  logic       last_rd;

  // reads only while the FIFO can take rows
  assign rden_o      = pos.busy & ~full_i & ft_go_ahead_i;
  assign pos.rd_step = rden_o;

  // block origin inside the macroblock
  assign org_x = {{(`FME_SWX_W-4){1'b0}}, pos.part_cnt[0], 3'b000};
  assign org_y = {{(`FME_SWY_W-4){1'b0}}, pos.part_cnt[1], pos.sub_cnt[0], 2'b00};

  assign mv_x_ext = {{(`FME_SWX_W-`FME_MV_W){mv_x_i[`FME_MV_W-1]}}, mv_x_i};
  assign mv_y_ext = {{(`FME_SWY_W-`FME_MV_W){mv_y_i[`FME_MV_W-1]}}, mv_y_i};

  assign pel_x = org_x + mv_x_ext + X_OFS + {{(`FME_SWX_W-4){1'b0}}, col_q};
  assign pel_y = org_y + mv_y_ext + Y_OFS + {{(`FME_SWY_W-5){1'b0}}, pos.row_cnt};

  // end of row once the buffer reaches 14 pixels
  assign span    = 5'(`FME_CACHE_PELS) - {1'b0, pel_x[3:0]};
  assign reach   = {1'b0, col_q} + span;
  assign last_rd = (reach >= 5'(`FME_ROW_PELS));

  assign pos.row_done = rden_o & last_rd;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      col_q <= '0;
    end else if (rden_o) begin
      col_q <= last_rd ? 4'd0 : reach[3:0];
    end
  end

  assign pel_x_o = pel_x;
  assign pel_y_o = pel_y;
  assign phase_o = pel_x[3:0];
  assign col_o   = col_q;

endmodule

/* fme_fetch/row_assembler.sv */
// Row assembler
//   read phase and buffer column registered with each read
//   aligned write of the returned cache word into the row buffer
//   row-done delay chain for the FIFO write strobe

`timescale 1ns/1ns
`include "fme_fetch_settings.svh"

module row_assembler (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       rden_i,
  input  logic                       row_done_i,
  input  logic [3:0]                 phase_i,
  input  logic [3:0]                 col_i,
  input  logic                       ack_i,
  input  fme_fetch_pkg::cache_word_t data_i,
  output fme_fetch_pkg::fifo_row_t   wrdata_o,
  output logic                       wren_o
);

  fme_fetch_pkg::pel_t word_pel [`FME_CACHE_PELS];

  logic [3:0] phase_q;
  logic [3:0] col_q;
  logic       done_d1;   // row done read, ack in this cycle
  logic       wren_q;

  // ************************************************************************
  // read side, captured for the ack one cycle later
  // ************************************************************************
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      phase_q <= '0;
      col_q   <= '0;
      done_d1 <= 1'b0;
      wren_q  <= 1'b0;
    end else begin
      if (rden_i) begin
        phase_q <= phase_i;
        col_q   <= col_i;
      end
      done_d1 <= rden_i & row_done_i;
      wren_q  <= done_d1;   // buffer complete after the last ack
    end
  end

  for (genvar gi = 0; gi < `FME_CACHE_PELS; gi++) begin : g_word
    assign word_pel[gi] = data_i[gi*`FME_PEL_W +: `FME_PEL_W];
  end

  // ************************************************************************
  // row buffer, one slot per output pixel
  // ************************************************************************
  for (genvar gk = 0; gk < `FME_ROW_PELS; gk++) begin : g_row
    fme_fetch_pkg::pel_t pel_q;
    logic [4:0]          src;   // cache pixel feeding this slot
    logic                hit;

    assign src = {1'b0, phase_q} + 5'(gk) - {1'b0, col_q};
    // slot at or right of the column, source still inside the word
    assign hit = (4'(gk) >= col_q) & ~src[4];

    always_ff @(posedge clk_i) begin
      if (ack_i && hit) begin
        pel_q <= word_pel[src[3:0]];
      end
    end

    assign wrdata_o[gk*`FME_PEL_W +: `FME_PEL_W] = pel_q;
  end

  assign wren_o = wren_q;

endmodule

/* fme_fetch/fme_fetch.sv */
// Reference pixel fetch for fractional motion estimation
//   block sequencer: shape, counters and vector table address
//   pixel address: search-window coordinates and cache read gating
//   row assembler: word alignment into 14-pixel FIFO rows

`timescale 1ns/1ns
`include "fme_fetch_settings.svh"

module fme_fetch (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  // control
  input  logic                            start_wr_i,
  input  fme_fetch_pkg::mb_type_e         mb_type_i,
  input  fme_fetch_pkg::sub_type_e        sub_mb_type_i,
  output logic [1:0]                      part_o,
  // motion-vector table
  input  logic signed [`FME_MV_W-1:0]     mv0_x_i,
  input  logic signed [`FME_MV_W-1:0]     mv0_y_i,
  output logic [3:0]                      mv0_addr_o,
  // downstream FIFO
  input  logic                            full_i,
  input  logic                            ft_go_ahead_i,
  output fme_fetch_pkg::fifo_row_t        wrdata_o,
  output logic                            wren_o,
  // search-window cache
  output logic signed [`FME_SWX_W-1:0]    sw_pel_x_o,
  output logic signed [`FME_SWY_W-1:0]    sw_pel_y_o,
  output logic                            rden_cache_o,
  output logic                            rddone_cache_o,
  input  logic                            ack_cache_i,
  input  fme_fetch_pkg::cache_word_t      rddata_cache_i
);

  fetch_pos_if pos_if ();

  logic [3:0] rd_phase;   // pel x mod 16 of the current read
  logic [3:0] rd_col;     // row buffer column of the current read

  block_sequencer u_seq (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .start_wr_i    (start_wr_i),
    .mb_type_i     (mb_type_i),
    .sub_mb_type_i (sub_mb_type_i),
    .mv0_addr_o    (mv0_addr_o),
    .part_o        (part_o),
    .rddone_o      (rddone_cache_o),
    .pos           (pos_if.seq)
  );

  pel_address u_addr (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .full_i        (full_i),
    .ft_go_ahead_i (ft_go_ahead_i),
    .mv_x_i        (mv0_x_i),
    .mv_y_i        (mv0_y_i),
    .pos           (pos_if.addr),
    .rden_o        (rden_cache_o),
    .pel_x_o       (sw_pel_x_o),
    .pel_y_o       (sw_pel_y_o),
    .phase_o       (rd_phase),
    .col_o         (rd_col)
  );

  row_assembler u_row (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .rden_i        (rden_cache_o),
    .row_done_i    (pos_if.row_done),
    .phase_i       (rd_phase),
    .col_i         (rd_col),
    .ack_i         (ack_cache_i),
    .data_i        (rddata_cache_i),
    .wrdata_o      (wrdata_o),
    .wren_o        (wren_o)
  );

endmodule

/* test/fme_fetch_assert.sv */
// Concurrent checks on the fetch unit, bound to its top level
//   cache reads gated by the FIFO handshake
//   FIFO write two cycles after the last read of a row
//   control outputs quiet during reset

`timescale 1ns/1ns

module fme_fetch_assert (
  input logic clk_i,
  input logic rst_n_i,
  input logic full_i,
  input logic go_ahead_i,
  input logic rden_i,
  input logic rddone_i,
  input logic row_done_i,
  input logic wren_i
);

  int fail_cnt = 0;   // read by the testbench summary

  a_rden_full: assert property (@(posedge clk_i) disable iff (!rst_n_i) rden_i |-> !full_i)
    else begin fail_cnt++; $error("cache read while the FIFO is full"); end

  a_rden_go: assert property (@(posedge clk_i) disable iff (!rst_n_i) rden_i |-> go_ahead_i)
    else begin fail_cnt++; $error("cache read without fetch go-ahead"); end

  // row buffer complete one cycle after the last ack
  a_wren_delay: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                                 row_done_i |-> ##2 wren_i)
    else begin fail_cnt++; $error("no FIFO write two cycles after the end of a row"); end

  a_reset_quiet: assert property (@(posedge clk_i) !rst_n_i |-> !rden_i && !rddone_i && !wren_i)
    else begin fail_cnt++; $error("control output active during reset"); end

endmodule

bind fme_fetch fme_fetch_assert u_assert (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .full_i     (full_i),
  .go_ahead_i (ft_go_ahead_i),
  .rden_i     (rden_cache_o),
  .rddone_i   (rddone_cache_o),
  .row_done_i (pos_if.row_done),
  .wren_i     (wren_o)
);

/* test/tb_fme_fetch.sv */
// Testbench for the FME reference fetch unit
//   clock, reset and FIFO back-pressure drive
//   search-window cache and motion-vector table models
//   reference rows and read addresses from the fetch rules
//   directed tests, compare tasks, watchdog and summary

`timescale 1ns/1ns
`include "fme_fetch_settings.svh"

module tb_fme_fetch;

  localparam int ROWS_TOTAL  = 44 + 44 + 56 + 56 + 80 + 80;
  localparam int CYCLE_LIMIT = ROWS_TOTAL * 2 * 2 + 500;   // stalls x two reads per row

  logic                          clk_i;
  logic                          rst_n_i;
  logic                          start_wr_i;
  fme_fetch_pkg::mb_type_e       mb_type_i;
  fme_fetch_pkg::sub_type_e      sub_mb_type_i;
  logic [1:0]                    part_o;
  logic signed [`FME_MV_W-1:0]   mv0_x_i;
  logic signed [`FME_MV_W-1:0]   mv0_y_i;
  logic [3:0]                    mv0_addr_o;
  logic                          full_i;
  logic                          ft_go_ahead_i;
  fme_fetch_pkg::fifo_row_t      wrdata_o;
  logic                          wren_o;
  logic signed [`FME_SWX_W-1:0]  sw_pel_x_o;
  logic signed [`FME_SWY_W-1:0]  sw_pel_y_o;
  logic                          rden_cache_o;
  logic                          rddone_cache_o;
  logic                          ack_cache_i;
  fme_fetch_pkg::cache_word_t    rddata_cache_i;

  integer seed     = 32'h9636;
  int     cycles   = 0;
  int     errors   = 0;
  int     checks   = 0;
  int     tests    = 0;
  int     failed   = 0;
  int     done_cnt = 0;
  bit     stall_en = 1'b0;

  logic signed [`FME_MV_W-1:0] vec_x [16];   // vector table, x components
  logic signed [`FME_MV_W-1:0] vec_y [16];

  fme_fetch_pkg::fifo_row_t got_rows  [$];
  fme_fetch_pkg::fifo_row_t exp_rows  [$];
  fme_fetch_pkg::fifo_row_t prev_rows [$];   // rows of the last unstalled 8x4 run
  logic [3:0]               got_addr  [$];
  logic [3:0]               exp_addr  [$];
  int                       got_part  [$];
  int                       exp_part  [$];
  int                       got_x     [$];
  int                       exp_x     [$];
  int                       got_y     [$];
  int                       exp_y     [$];

  fme_fetch dut_i (.*);

  assign mv0_x_i = vec_x[mv0_addr_o];
  assign mv0_y_i = vec_y[mv0_addr_o];

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // search-window content rule
  function automatic fme_fetch_pkg::pel_t pel_value(input int x, input int y);
    return 8'(x * 7 + y * 13);
  endfunction

  // **************************************************************************
  // environment models
  // **************************************************************************
  always @(posedge clk_i) begin : cache_model
    int   base;
    int   y;
    logic rd;
    rd   = rden_cache_o;
    base = int'(sw_pel_x_o) & ~15;   // aligned 16-pixel group
    y    = int'(sw_pel_y_o);
    #1;
    ack_cache_i <= rd;
    for (int i = 0; i < `FME_CACHE_PELS; i++) begin
      rddata_cache_i[i*`FME_PEL_W +: `FME_PEL_W] <= pel_value(base + i, y);
    end
  end

  always @(posedge clk_i) begin
    #1;
    if (stall_en) begin
      full_i        <= (($random(seed) & 3) == 0);
      ft_go_ahead_i <= (($random(seed) & 3) != 0);
    end else begin
      full_i        <= 1'b0;
      ft_go_ahead_i <= 1'b1;
    end
  end

  // monitor and watchdog
  always @(posedge clk_i) begin
    cycles++;
    if (rden_cache_o) begin
      got_addr.push_back(mv0_addr_o);
      got_part.push_back(int'(part_o));
      got_x.push_back(int'(sw_pel_x_o));
      got_y.push_back(int'(sw_pel_y_o));
    end
    if (wren_o) got_rows.push_back(wrdata_o);
    if (rddone_cache_o) done_cnt++;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Done: errors found");
      $finish;
    end
  end

  task automatic check_row(input string name, input fme_fetch_pkg::fifo_row_t got,
                           input fme_fetch_pkg::fifo_row_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("ERR %0t %s got %0d exp %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input logic [3:0] got, input logic [3:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t %s got %0d exp %0d", $time, name, got, exp);
    end
  endtask

  task automatic fill_vectors();
    for (int i = 0; i < 16; i++) begin
      vec_x[i] = 6'(-29 + int'($unsigned($random(seed)) % 61));
      vec_y[i] = 6'(-16 + int'($unsigned($random(seed)) % 32));   // keeps pel y in range
    end
  endtask

  // **************************************************************************
  // reference model, rows and reads in fetch order
  // **************************************************************************
  task automatic build_expected(input fme_fetch_pkg::mb_type_e mb,
                                input fme_fetch_pkg::sub_type_e sub);
    int                       n_part;
    int                       n_sub;
    int                       n_row;
    int                       adr;
    int                       x0;
    int                       y;
    int                       ph;
    fme_fetch_pkg::fifo_row_t row;
    n_part = (mb == fme_fetch_pkg::P_16X16 || mb == fme_fetch_pkg::P_8X16) ? 2 : 4;
    n_sub  = (mb == fme_fetch_pkg::P_8X8 && sub == fme_fetch_pkg::SUB_8X4) ? 2 : 1;
    n_row  = (n_part == 2) ? 22 : ((n_sub == 2) ? 10 : 14);
    exp_rows.delete();
    exp_addr.delete();
    exp_part.delete();
    exp_x.delete();
    exp_y.delete();
    for (int p = 0; p < n_part; p++) begin
      for (int s = 0; s < n_sub; s++) begin
        case (mb)
          fme_fetch_pkg::P_16X16: adr = 0;
          fme_fetch_pkg::P_16X8:  adr = 8 * (p / 2);
          default:                adr = 4 * p + 2 * s;
        endcase
        for (int r = 0; r < n_row; r++) begin
          x0 = 8 * (p % 2) + vec_x[adr] + `FME_SR_HOR - 3;
          y  = 8 * (p / 2) + 4 * s + vec_y[adr] + `FME_SR_VER + r;
          for (int k = 0; k < `FME_ROW_PELS; k++) begin
            row[k*`FME_PEL_W +: `FME_PEL_W] = pel_value(x0 + k, y);
          end
          exp_rows.push_back(row);
          exp_addr.push_back(4'(adr));
          exp_part.push_back(p);
          exp_x.push_back(x0);
          exp_y.push_back(y);
          ph = x0 % `FME_CACHE_PELS;
          if (ph > `FME_CACHE_PELS - `FME_ROW_PELS) begin   // second aligned read
            exp_addr.push_back(4'(adr));
            exp_part.push_back(p);
            exp_x.push_back(x0 + `FME_CACHE_PELS - ph);
            exp_y.push_back(y);
          end
        end
      end
    end
  endtask

  // one macroblock from start to the last FIFO write, entered 1 ns after an edge
  task automatic run_mb(input fme_fetch_pkg::mb_type_e mb, input fme_fetch_pkg::sub_type_e sub,
                        input bit stall);
    build_expected(mb, sub);
    got_rows.delete();
    got_addr.delete();
    got_part.delete();
    got_x.delete();
    got_y.delete();
    done_cnt      = 0;
    stall_en      = stall;
    mb_type_i     = mb;
    sub_mb_type_i = sub;
    start_wr_i    = 1'b1;
    @(posedge clk_i);
    #1;
    start_wr_i = 1'b0;
    while (done_cnt == 0) @(posedge clk_i);
    stall_en = 1'b0;
    repeat (4) @(posedge clk_i);   // last write lands two cycles after done
    #1;
    check_count("rows written", got_rows.size(), exp_rows.size());
    check_count("cache reads", got_addr.size(), exp_addr.size());
    check_count("rddone_cache_o pulses", done_cnt, 1);
    for (int i = 0; i < got_rows.size() && i < exp_rows.size(); i++) begin
      check_row("wrdata_o", got_rows[i], exp_rows[i]);
    end
    for (int i = 0; i < got_addr.size() && i < exp_addr.size(); i++) begin
      check_addr("mv0_addr_o", got_addr[i], exp_addr[i]);
      check_count("part_o", got_part[i], exp_part[i]);
      check_count("sw_pel_x_o", got_x[i], exp_x[i]);
      check_count("sw_pel_y_o", got_y[i], exp_y[i]);
    end
  endtask

  task automatic report_test(input string name, input int err0);
    tests++;
    if (errors != err0) failed++;
    $display("test %0d %s %s", tests, name, (errors == err0) ? "ok" : "FAILED");
  endtask

  // **************************************************************************
  // directed tests
  // **************************************************************************
  task automatic aligned_16x16();
    int err0;
    err0 = errors;
    fill_vectors();
    vec_x[0] = 6'sd3;   // left block starts at x 32, phase 0
    run_mb(fme_fetch_pkg::P_16X16, fme_fetch_pkg::SUB_8X8, 1'b0);
    report_test("16x16 aligned", err0);
  endtask

  task automatic unaligned_8x16();
    int err0;
    err0 = errors;
    fill_vectors();
    vec_x[0] = 6'sd0;   // phase 13
    vec_x[4] = 6'sd0;   // phase 5
    run_mb(fme_fetch_pkg::P_8X16, fme_fetch_pkg::SUB_8X8, 1'b0);
    report_test("8x16 unaligned", err0);
  endtask

  task automatic quadrant_partitions();
    int err0;
    err0 = errors;
    fill_vectors();
    run_mb(fme_fetch_pkg::P_16X8, fme_fetch_pkg::SUB_8X8, 1'b0);
    run_mb(fme_fetch_pkg::P_8X8, fme_fetch_pkg::SUB_8X8, 1'b0);
    report_test("16x8 and 8x8", err0);
  endtask

  task automatic sub_block_8x4();
    int err0;
    err0 = errors;
    fill_vectors();
    run_mb(fme_fetch_pkg::P_8X8, fme_fetch_pkg::SUB_8X4, 1'b0);
    prev_rows = got_rows;
    report_test("8x8 with 8x4 sub-blocks", err0);
  endtask

  // same vectors as the 8x4 run, random FIFO back-pressure
  task automatic stalled_rerun();
    int err0;
    err0 = errors;
    run_mb(fme_fetch_pkg::P_8X8, fme_fetch_pkg::SUB_8X4, 1'b1);
    check_count("rows against unstalled run", got_rows.size(), prev_rows.size());
    for (int i = 0; i < got_rows.size() && i < prev_rows.size(); i++) begin
      check_row("wrdata_o", got_rows[i], prev_rows[i]);
    end
    report_test("back-pressure", err0);
  endtask

  initial begin
    rst_n_i        = 1'b0;
    start_wr_i     = 1'b0;
    mb_type_i      = fme_fetch_pkg::P_16X16;
    sub_mb_type_i  = fme_fetch_pkg::SUB_8X8;
    full_i         = 1'b0;
    ft_go_ahead_i  = 1'b1;
    ack_cache_i    = 1'b0;
    rddata_cache_i = '0;
    fill_vectors();
    repeat (2) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    aligned_16x16();
    unaligned_8x16();
    quadrant_partitions();
    sub_block_8x4();
    stalled_rerun();
    $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
             tests, failed, checks, errors, dut_i.u_assert.fail_cnt);
    if (errors == 0 && dut_i.u_assert.fail_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+common
common/fme_fetch_pkg.sv
common/fetch_pos_if.sv
fme_fetch/block_sequencer.sv
fme_fetch/pel_address.sv
fme_fetch/row_assembler.sv
fme_fetch/fme_fetch.sv
test/fme_fetch_assert.sv
test/tb_fme_fetch.sv

/* Bender.yml */
package:
  name: fme_fetch

sources:
  - include_dirs:
      - common
    files:
      - common/fme_fetch_pkg.sv
      - common/fetch_pos_if.sv
      - fme_fetch/block_sequencer.sv
      - fme_fetch/pel_address.sv
      - fme_fetch/row_assembler.sv
      - fme_fetch/fme_fetch.sv
      - target: test
        files:
          - test/fme_fetch_assert.sv
          - test/tb_fme_fetch.sv
